// File: hw/symm_norm_pkg.sv
`default_nettype none

package symm_norm_pkg;

    // Element and degree word width.
    localparam int DATA_W = 26;

    // Default Q format of elements, degrees and quotients.
    localparam int FRAC_DEF = 13;

    // Root width at the default format, half of (DATA_W-1+FRAC_DEF) rounded up.
    localparam int ROOT_MAX_W = (DATA_W + FRAC_DEF) / 2;

    // Matrix element, row degree or normalized quotient.
    typedef logic signed [DATA_W-1:0] sample_t;

    // Row number within the 4x4 matrix.
    typedef logic [1:0] row_idx_t;

endpackage

`default_nettype wire

// File: hw/sqrt_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module sqrt_pipe #(
    parameter int FRAC_W = symm_norm_pkg::FRAC_DEF,
    localparam int ROOT_W = (symm_norm_pkg::DATA_W + FRAC_W) / 2
) (
    input  logic                   clk_sqrt,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  symm_norm_pkg::sample_t in_sum,
    output logic                   root_valid,
    output logic [ROOT_W-1:0]      root
);

    import symm_norm_pkg::*;

    localparam int RAD_W = 2 * ROOT_W;
    localparam int REM_W = ROOT_W + 3;

    logic [DATA_W-2:0] sum_mag;
    logic [RAD_W-1:0]  rad_in;
    logic [RAD_W+1:0]  chk_root;
    logic [RAD_W+1:0]  chk_rad;

    // Negative degrees count as zero.
    assign sum_mag = in_sum[DATA_W-1] ? '0 : in_sum[DATA_W-2:0];

    // Scale up so the integer root lands in the same Q format.
    assign rad_in = RAD_W'(sum_mag) << FRAC_W;

    // Non-restoring square root, one root bit per stage.
    for (genvar s = 0; s < ROOT_W; s++) begin : g_stage
        localparam int B = ROOT_W - 1 - s;

        logic                    v_prev;
        logic [RAD_W-1:0]        rad_prev;
        logic signed [REM_W-1:0] rem_prev;
        logic [ROOT_W-1:0]       root_prev;
        logic signed [REM_W-1:0] rem_shift;
        logic signed [REM_W-1:0] rem_next;
        logic [ROOT_W-1:0]       root_next;

        logic                    v_r;
        logic [RAD_W-1:0]        rad_r;
        logic signed [REM_W-1:0] rem_r;
        logic [ROOT_W-1:0]       root_r;

        if (s == 0) begin : g_head
            assign v_prev    = in_valid;
            assign rad_prev  = rad_in;
            assign rem_prev  = '0;
            assign root_prev = '0;
        end else begin : g_link
            assign v_prev    = g_stage[s-1].v_r;
            assign rad_prev  = g_stage[s-1].rad_r;
            assign rem_prev  = g_stage[s-1].rem_r;
            assign root_prev = g_stage[s-1].root_r;
        end

        // Bring down the next two radicand bits.
        assign rem_shift = {rem_prev[REM_W-3:0], rad_prev[2*B+1 -: 2]};

        // Subtract 4q+1 after a positive remainder, add 4q+3 after a negative one.
        assign rem_next = rem_prev[REM_W-1] ? rem_shift + REM_W'({root_prev, 2'b11})
                                            : rem_shift - REM_W'({root_prev, 2'b01});

        assign root_next = {root_prev[ROOT_W-2:0], ~rem_next[REM_W-1]};

        always_ff @(posedge clk_sqrt) begin
            if (!rst_n) begin
                v_r <= 1'b0;
            end else begin
                v_r <= v_prev;
            end
        end

        always_ff @(posedge clk_sqrt) begin
            if (v_prev) begin
                rad_r  <= rad_prev;
                rem_r  <= rem_next;
                root_r <= root_next;
            end
        end
    end

    assign root_valid = g_stage[ROOT_W-1].v_r;
    assign root       = g_stage[ROOT_W-1].root_r;

    assign chk_root = (RAD_W+2)'(root);
    assign chk_rad  = (RAD_W+2)'(g_stage[ROOT_W-1].rad_r);

    // Floor root of the radicand that entered with this row.
    a_root_floor: assert property (@(posedge clk_sqrt) disable iff (!rst_n)
        root_valid |-> (chk_root * chk_root <= chk_rad)
                    && ((chk_root + 1'b1) * (chk_root + 1'b1) > chk_rad));

endmodule

`default_nettype wire

// File: hw/row_delay.sv
`timescale 1ns/100ps
`default_nettype none

module row_delay #(
    parameter int STAGES = symm_norm_pkg::ROOT_MAX_W
) (
    input  logic                    clk_sqrt,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  symm_norm_pkg::row_idx_t in_row_idx,
    input  symm_norm_pkg::sample_t  in_e0,
    input  symm_norm_pkg::sample_t  in_e1,
    input  symm_norm_pkg::sample_t  in_e2,
    input  symm_norm_pkg::sample_t  in_e3,
    output logic                    d_valid,
    output symm_norm_pkg::row_idx_t d_row_idx,
    output symm_norm_pkg::sample_t  d_e0,
    output symm_norm_pkg::sample_t  d_e1,
    output symm_norm_pkg::sample_t  d_e2,
    output symm_norm_pkg::sample_t  d_e3
);

    import symm_norm_pkg::*;

    logic [STAGES-1:0] v_r;
    row_idx_t          idx_r [STAGES];
    sample_t           e_r   [STAGES][4];
    sample_t           e_in  [4];

    assign e_in[0] = in_e0;
    assign e_in[1] = in_e1;
    assign e_in[2] = in_e2;
    assign e_in[3] = in_e3;

    always_ff @(posedge clk_sqrt) begin
        if (!rst_n) begin
            v_r <= '0;
        end else begin
            v_r <= (v_r << 1) | STAGES'(in_valid);
        end
    end

    // Payload only moves with a valid row behind it.
    always_ff @(posedge clk_sqrt) begin
        if (in_valid) begin
            idx_r[0] <= in_row_idx;
            e_r[0]   <= e_in;
        end
        for (int k = 1; k < STAGES; k++) begin
            if (v_r[k-1]) begin
                idx_r[k] <= idx_r[k-1];
                e_r[k]   <= e_r[k-1];
            end
        end
    end

    assign d_valid   = v_r[STAGES-1];
    assign d_row_idx = idx_r[STAGES-1];
    assign d_e0      = e_r[STAGES-1][0];
    assign d_e1      = e_r[STAGES-1][1];
    assign d_e2      = e_r[STAGES-1][2];
    assign d_e3      = e_r[STAGES-1][3];

endmodule

`default_nettype wire

// File: hw/row_divider.sv
`timescale 1ns/100ps
`default_nettype none

module row_divider #(
    parameter int FRAC_W = symm_norm_pkg::FRAC_DEF,
    localparam int ROOT_W = (symm_norm_pkg::DATA_W + FRAC_W) / 2
) (
    input  logic                    clk_sqrt,
    input  logic                    rst_n,
    input  logic                    root_valid,
    input  logic [ROOT_W-1:0]       root,
    input  symm_norm_pkg::row_idx_t row_idx,
    input  symm_norm_pkg::sample_t  e0,
    input  symm_norm_pkg::sample_t  e1,
    input  symm_norm_pkg::sample_t  e2,
    input  symm_norm_pkg::sample_t  e3,
    output logic                    out_valid,
    output symm_norm_pkg::row_idx_t out_row_idx,
    output symm_norm_pkg::sample_t  out_q0,
    output symm_norm_pkg::sample_t  out_q1,
    output symm_norm_pkg::sample_t  out_q2,
    output symm_norm_pkg::sample_t  out_q3,
    output logic                    out_div_zero
);

    import symm_norm_pkg::*;

    localparam int NUM_W = DATA_W + FRAC_W;

    logic                    root_zero;
    logic signed [NUM_W-1:0] den;
    logic signed [NUM_W-1:0] num [4];
    logic signed [NUM_W-1:0] quo [4];
    sample_t                 e_in   [4];
    sample_t                 q_next [4];
    sample_t                 q_r    [4];

    assign e_in[0] = e0;
    assign e_in[1] = e1;
    assign e_in[2] = e2;
    assign e_in[3] = e3;

    assign root_zero = (root == '0);

    // Root is unsigned, so zero-extend before the signed divide.
    assign den = NUM_W'({1'b0, root});

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            num[i]    = NUM_W'(e_in[i]) <<< FRAC_W;
            quo[i]    = num[i] / den;
            // Wraps to the element width.
            q_next[i] = root_zero ? '0 : quo[i][DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_sqrt) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            out_div_zero <= 1'b0;
        end else begin
            out_valid    <= root_valid;
            out_div_zero <= root_valid && root_zero;
        end
    end

    always_ff @(posedge clk_sqrt) begin
        if (root_valid) begin
            out_row_idx <= row_idx;
            q_r         <= q_next;
        end
    end

    assign out_q0 = q_r[0];
    assign out_q1 = q_r[1];
    assign out_q2 = q_r[2];
    assign out_q3 = q_r[3];

    // A zero root yields a flagged, all-zero row.
    a_zero_row: assert property (@(posedge clk_sqrt) disable iff (!rst_n)
        out_div_zero |-> out_valid && out_q0 == '0 && out_q1 == '0
                      && out_q2 == '0 && out_q3 == '0);

endmodule

`default_nettype wire

// File: hw/symm_norm_top.sv
`timescale 1ns/100ps
`default_nettype none

module symm_norm_top #(
    parameter int FRAC_W = symm_norm_pkg::FRAC_DEF
) (
    input  logic                    clk_sqrt,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  symm_norm_pkg::row_idx_t in_row_idx,
    input  symm_norm_pkg::sample_t  in_e0,
    input  symm_norm_pkg::sample_t  in_e1,
    input  symm_norm_pkg::sample_t  in_e2,
    input  symm_norm_pkg::sample_t  in_e3,
    input  symm_norm_pkg::sample_t  in_sum,
    output logic                    out_valid,
    output symm_norm_pkg::row_idx_t out_row_idx,
    output symm_norm_pkg::sample_t  out_q0,
    output symm_norm_pkg::sample_t  out_q1,
    output symm_norm_pkg::sample_t  out_q2,
    output symm_norm_pkg::sample_t  out_q3,
    output logic                    out_div_zero
);

    import symm_norm_pkg::*;

    localparam int ROOT_W = (DATA_W + FRAC_W) / 2;

    logic              root_valid;
    logic [ROOT_W-1:0] root;
    logic              d_valid;
    row_idx_t          d_row_idx;
    sample_t           d_e0;
    sample_t           d_e1;
    sample_t           d_e2;
    sample_t           d_e3;

    sqrt_pipe #(
        .FRAC_W (FRAC_W)
    ) u_sqrt (
        .clk_sqrt   (clk_sqrt),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sum     (in_sum),
        .root_valid (root_valid),
        .root       (root)
    );

    // Elements wait one cycle per root bit.
    row_delay #(
        .STAGES (ROOT_W)
    ) u_delay (
        .clk_sqrt   (clk_sqrt),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_row_idx (in_row_idx),
        .in_e0      (in_e0),
        .in_e1      (in_e1),
        .in_e2      (in_e2),
        .in_e3      (in_e3),
        .d_valid    (d_valid),
        .d_row_idx  (d_row_idx),
        .d_e0       (d_e0),
        .d_e1       (d_e1),
        .d_e2       (d_e2),
        .d_e3       (d_e3)
    );

    row_divider #(
        .FRAC_W (FRAC_W)
    ) u_div (
        .clk_sqrt     (clk_sqrt),
        .rst_n        (rst_n),
        .root_valid   (root_valid),
        .root         (root),
        .row_idx      (d_row_idx),
        .e0           (d_e0),
        .e1           (d_e1),
        .e2           (d_e2),
        .e3           (d_e3),
        .out_valid    (out_valid),
        .out_row_idx  (out_row_idx),
        .out_q0       (out_q0),
        .out_q1       (out_q1),
        .out_q2       (out_q2),
        .out_q3       (out_q3),
        .out_div_zero (out_div_zero)
    );

    // Delay line and root pipeline stay in step.
    a_align: assert property (@(posedge clk_sqrt) disable iff (!rst_n)
        d_valid == root_valid);

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD_NS = 5,
    parameter int RESET_CYCLES   = 4
) (
    output logic clk_sqrt,
    output logic rst_n
);

    initial begin
        clk_sqrt = 1'b0;
        forever #(HALF_PERIOD_NS) clk_sqrt = ~clk_sqrt;
    end

    // Release just after an edge, like the rest of the stimulus.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sqrt);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/symm_norm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module symm_norm_tb;

    import symm_norm_pkg::*;

    localparam int LATENCY         = 20;
    localparam int MAX_GAP         = 5;
    localparam int IDLE_CYCLES     = 30;
    localparam int DRAIN_IDLE      = 5;
    localparam int N_TESTS         = 5;
    localparam int N_RAND_B2B      = 300;
    localparam int N_RAND_GAP      = 60;
    localparam int N_STROBES       = 1 + 3 + 4 + N_RAND_B2B + N_RAND_GAP;
    localparam int WATCHDOG_CYCLES = N_STROBES * (MAX_GAP + 1)
                                   + N_TESTS * (LATENCY + DRAIN_IDLE)
                                   + IDLE_CYCLES + 4 + 200;

    typedef struct packed {
        row_idx_t    idx;
        sample_t     q0;
        sample_t     q1;
        sample_t     q2;
        sample_t     q3;
        logic        div_zero;
        logic [31:0] cyc;
    } exp_row_t;

    logic     clk_sqrt;
    logic     rst_n;
    logic     in_valid;
    row_idx_t in_row_idx;
    sample_t  in_e0;
    sample_t  in_e1;
    sample_t  in_e2;
    sample_t  in_e3;
    sample_t  in_sum;
    logic     out_valid;
    row_idx_t out_row_idx;
    sample_t  out_q0;
    sample_t  out_q1;
    sample_t  out_q2;
    sample_t  out_q3;
    logic     out_div_zero;

    exp_row_t    exp_q [$];
    int unsigned cyc = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    clk_gen u_clk (
        .clk_sqrt (clk_sqrt),
        .rst_n    (rst_n)
    );

    symm_norm_top uut (
        .clk_sqrt     (clk_sqrt),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_row_idx   (in_row_idx),
        .in_e0        (in_e0),
        .in_e1        (in_e1),
        .in_e2        (in_e2),
        .in_e3        (in_e3),
        .in_sum       (in_sum),
        .out_valid    (out_valid),
        .out_row_idx  (out_row_idx),
        .out_q0       (out_q0),
        .out_q1       (out_q1),
        .out_q2       (out_q2),
        .out_q3       (out_q3),
        .out_div_zero (out_div_zero)
    );

    always @(posedge clk_sqrt) cyc <= cyc + 1;

    // Largest r with r*r <= x, built one bit at a time.
    function automatic logic [31:0] floor_sqrt(input longint unsigned x);
        longint unsigned r;
        longint unsigned t;
        r = 0;
        for (int b = 24; b >= 0; b--) begin
            t = r | (64'd1 << b);
            if (t * t <= x) r = t;
        end
        return r[31:0];
    endfunction

    function automatic sample_t norm_quot(input sample_t e, input logic [31:0] root);
        longint num;
        longint q;
        if (root == 0) return '0;
        num = longint'(e) * (longint'(1) << FRAC_DEF);
        q   = num / longint'(root);
        return sample_t'(q);
    endfunction

    function automatic exp_row_t ref_row(input row_idx_t idx, input sample_t e0,
                                         input sample_t e1, input sample_t e2,
                                         input sample_t e3, input sample_t sum,
                                         input int unsigned at_cyc);
        exp_row_t        r;
        longint unsigned rad;
        logic [31:0]     root;
        if (sum < 0) rad = 0;
        else rad = longint'(sum) << FRAC_DEF;
        root       = floor_sqrt(rad);
        r.idx      = idx;
        r.q0       = norm_quot(e0, root);
        r.q1       = norm_quot(e1, root);
        r.q2       = norm_quot(e2, root);
        r.q3       = norm_quot(e3, root);
        r.div_zero = (root == 0);
        r.cyc      = at_cyc;
        return r;
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input row_idx_t got, input row_idx_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Entered and left 1 ns after a rising edge.
    task automatic send_row(input row_idx_t idx, input sample_t e0, input sample_t e1,
                            input sample_t e2, input sample_t e3, input sample_t sum);
        in_valid   = 1'b1;
        in_row_idx = idx;
        in_e0      = e0;
        in_e1      = e1;
        in_e2      = e2;
        in_e3      = e3;
        in_sum     = sum;
        exp_q.push_back(ref_row(idx, e0, e1, e2, e3, sum, cyc));
        @(posedge clk_sqrt);
        #1 in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk_sqrt);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LATENCY + DRAIN_IDLE) begin
            idle(1);
            waited++;
        end
        idle(DRAIN_IDLE);
        $display("test %s: %0d errors", name, n_errors - errs_before);
    endtask

    function automatic sample_t pick_element();
        return sample_t'($urandom);
    endfunction

    // Mostly positive degrees over a wide range of sizes, some zero or negative.
    function automatic sample_t draw_sum();
        if ($urandom % 8 == 0) return sample_t'(-($urandom % 4096));
        return sample_t'(($urandom & 32'h01FF_FFFF) >> ($urandom % 24));
    endfunction

    always @(negedge clk_sqrt) begin : compare
        exp_row_t rec;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("out_valid was high at cycle %0d with no row outstanding", cyc);
            end else begin
                rec = exp_q.pop_front();
                check_idx("out_row_idx", out_row_idx, rec.idx);
                check_sample("out_q0", out_q0, rec.q0);
                check_sample("out_q1", out_q1, rec.q1);
                check_sample("out_q2", out_q2, rec.q2);
                check_sample("out_q3", out_q3, rec.q3);
                check_flag("out_div_zero", out_div_zero, rec.div_zero);
                if (cyc - rec.cyc != LATENCY) begin
                    n_errors++;
                    $display("row came out %0d cycles after its strobe instead of %0d",
                             cyc - rec.cyc, LATENCY);
                end
            end
        end
    end

    initial begin : stimulus
        int errs;
        in_valid   = 1'b0;
        in_row_idx = '0;
        in_e0      = '0;
        in_e1      = '0;
        in_e2      = '0;
        in_e3      = '0;
        in_sum     = '0;
        void'($urandom(32'hed964b65));
        wait (rst_n === 1'b1);

        errs = n_errors;
        idle(IDLE_CYCLES);
        send_row(2'd0, 26'sd12345, -26'sd8192, 26'sd0, 26'sd100000, 26'sd8192);
        end_test("reset_and_unit_degree", errs);

        errs = n_errors;
        send_row(2'd1, 26'sd8192, -26'sd12289, 26'sd3, -26'sd1, 26'sd32768);
        send_row(2'd2, 26'sd24576, -26'sd24577, 26'sd33554431, -26'sd33554431, 26'sd73728);
        send_row(2'd3, -26'sd40000, 26'sd40000, 26'sd7, -26'sd7, 26'sd131072);
        end_test("perfect_squares", errs);

        errs = n_errors;
        send_row(2'd0, 26'sd8192, -26'sd8192, 26'sd1, -26'sd1, 26'sd0);
        send_row(2'd1, 26'sd500, 26'sd600, 26'sd700, 26'sd800, -26'sd8192);
        send_row(2'd2, -26'sd3, 26'sd3, 26'sd0, 26'sd9, -26'sd1);
        send_row(2'd3, 26'sd1, 26'sd2, 26'sd3, 26'sd4, sample_t'(26'h2000000));
        end_test("zero_and_negative_sums", errs);

        errs = n_errors;
        for (int k = 0; k < N_RAND_B2B; k++) begin
            send_row(row_idx_t'(k), pick_element(), pick_element(), pick_element(),
                     pick_element(), draw_sum());
        end
        end_test("random_back_to_back", errs);

        errs = n_errors;
        for (int k = 0; k < N_RAND_GAP; k++) begin
            send_row(row_idx_t'($urandom), pick_element(), pick_element(), pick_element(),
                     pick_element(), draw_sum());
            idle($urandom % (MAX_GAP + 1));
        end
        end_test("random_gaps", errs);

        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%0d expected rows never came out", exp_q.size());
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_sqrt);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: symm_norm.f
hw/symm_norm_pkg.sv
hw/sqrt_pipe.sv
hw/row_delay.sv
hw/row_divider.sv
hw/symm_norm_top.sv
sim/clk_gen.sv
sim/symm_norm_tb.sv
